/* bench/tb_sink_finder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "node_cfg.svh"

module tb_sink_finder;

    localparam int          ACK_TIMEOUT = 4000;     // cycles, covers a full scan.
    localparam logic [15:0] LFSR_SEED   = 16'(80741);

    logic                   clock = 1'b0;
    logic                   rst_n;
    logic                   req;
    sink_pkg::host_cmd_t    cmd;
    logic                   ack;
    sink_pkg::host_rsp_t    rsp;

    // testbench copy of the node tables.
    logic [15:0] sink_tab [`NUM_SINKS];
    logic [15:0] nbr_tab  [`NUM_NEIGHBORS];
    logic [15:0] clu_tab  [`NUM_NEIGHBORS];
    logic [15:0] my_cl;
    logic [15:0] lfsr_state;

    int  checks;
    int  errors;
    int  tests_run;
    int  tests_bad;
    int  errors_at_start;
    bit  hung;                                      // a handshake timed out.

    sink_finder_top i_dut (
        .clock (clock),
        .rst_n (rst_n),
        .req   (req),
        .cmd   (cmd),
        .ack   (ack),
        .rsp   (rsp)
    );

    always #5 clock = ~clock;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random source and reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1.
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    // first neighbor in a foreign cluster whose id is a sink, neighbor-major.
    function automatic sink_pkg::scan_result_t model_scan();
        sink_pkg::scan_result_t r;
        r = '0;
        for (int i = 0; i < `NUM_NEIGHBORS; i++) begin
            for (int j = 0; j < `NUM_SINKS; j++) begin
                if (!r.found && clu_tab[i] != my_cl && nbr_tab[i] == sink_tab[j]) begin
                    r.found        = 1'b1;
                    r.neighbor_idx = 6'(i);
                    r.sink_idx     = 4'(j);
                end
            end
        end
        return r;
    endfunction

    function automatic sink_pkg::host_rsp_t make_rsp(input logic ok, input logic [15:0] data);
        sink_pkg::host_rsp_t r;
        r.ok   = ok;
        r.data = data;
        return r;
    endfunction

    function automatic sink_pkg::host_cmd_t make_cmd(input sink_pkg::host_op_e op,
                                                     input logic [15:0] a,
                                                     input logic [15:0] d);
        sink_pkg::host_cmd_t c;
        c.op              = op;
        c.payload.wr.addr = a;                      // config reads this half as my_cluster.
        c.payload.wr.data = d;
        return c;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_rsp(input string what, input sink_pkg::host_rsp_t got,
                             input sink_pkg::host_rsp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", what, got, exp);
        end
    endtask

    task automatic check_result(input string what, input sink_pkg::scan_result_t got,
                                input sink_pkg::scan_result_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", what, got, exp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host driver.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (ack !== level && cycles < ACK_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (ack !== level) begin
            hung = 1'b1;
            errors++;
            $display("timeout: ack did not go to %0b within %0d cycles", level, ACK_TIMEOUT);
        end
    endtask

    // one four-phase transfer.
    task automatic host_xfer(input sink_pkg::host_cmd_t c, output sink_pkg::host_rsp_t r);
        r = '0;
        if (hung) return;
        @(posedge clock);
        req <= 1'b1;
        cmd <= c;
        wait_ack(1'b1);
        if (hung) return;
        r = rsp;                                    // sampled mid-cycle, stable.
        @(posedge clock);
        req <= 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic write_word(input logic [15:0] addr, input logic [15:0] data);
        sink_pkg::host_rsp_t r;
        host_xfer(make_cmd(sink_pkg::OP_WRITE, addr, data), r);
        check_rsp("rsp", r, make_rsp(1'b1, 16'h0));
    endtask

    task automatic set_cluster(input logic [15:0] cl);
        sink_pkg::host_rsp_t r;
        my_cl = cl;
        host_xfer(make_cmd(sink_pkg::OP_CONFIG, cl, 16'h0), r);
        check_rsp("rsp", r, make_rsp(1'b1, 16'h0));
    endtask

    task automatic load_tables();
        for (int j = 0; j < `NUM_SINKS; j++)
            write_word(`SINK_BASE + 16'(2 * j), sink_tab[j]);
        for (int i = 0; i < `NUM_NEIGHBORS; i++) begin
            write_word(`NEIGHBOR_BASE + 16'(2 * i), nbr_tab[i]);
            write_word(`CLUSTER_BASE + 16'(2 * i), clu_tab[i]);
        end
    endtask

    // start a scan, read the result back and compare.
    task automatic scan_and_check(input sink_pkg::scan_result_t exp);
        sink_pkg::host_rsp_t r;
        host_xfer(make_cmd(sink_pkg::OP_START, 16'h0, 16'h0), r);
        check_rsp("rsp", r, make_rsp(1'b1, 16'h0));
        host_xfer(make_cmd(sink_pkg::OP_RESULT, 16'h0, 16'h0), r);
        check_rsp("rsp", r, make_rsp(1'b1, exp));
        check_result("rsp.data", sink_pkg::scan_result_t'(r.data), exp);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != errors_at_start) tests_bad++;
        $display("%s: %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    function automatic sink_pkg::scan_result_t hit_at(input int i, input int j);
        sink_pkg::scan_result_t r;
        r              = '0;
        r.found        = 1'b1;
        r.neighbor_idx = 6'(i);
        r.sink_idx     = 4'(j);
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset_state();
        sink_pkg::host_rsp_t r;
        host_xfer(make_cmd(sink_pkg::OP_RESULT, 16'h0, 16'h0), r);
        check_rsp("rsp", r, make_rsp(1'b1, 16'h0));
        end_test("reset_state");
    endtask

    task automatic test_cmd_responses();
        write_word(`SINK_BASE, 16'h1234);
        set_cluster(16'h0003);
        end_test("cmd_responses");
    endtask

    task automatic test_single_match();
        for (int j = 0; j < `NUM_SINKS; j++) sink_tab[j] = 16'h0100 + 16'(j);
        for (int i = 0; i < `NUM_NEIGHBORS; i++) begin
            nbr_tab[i] = 16'h0200 + 16'(i);         // no overlap with sink ids.
            clu_tab[i] = 16'h0005;
        end
        nbr_tab[37] = sink_tab[11];
        load_tables();
        set_cluster(16'h0007);
        scan_and_check(hit_at(37, 11));
        end_test("single_match");
    endtask

    task automatic test_own_cluster();
        clu_tab[37] = my_cl;
        write_word(`CLUSTER_BASE + 16'(2 * 37), clu_tab[37]);
        scan_and_check('0);
        end_test("own_cluster");
    endtask

    task automatic test_first_match();
        clu_tab[37] = 16'h0005;
        sink_tab[4] = 16'h0AAA;                     // two sinks match neighbor 20.
        sink_tab[9] = 16'h0AAA;
        nbr_tab[12] = 16'h0AAA;
        clu_tab[12] = my_cl;                        // earlier, but own cluster.
        nbr_tab[20] = 16'h0AAA;
        nbr_tab[50] = 16'h0AAA;
        load_tables();
        scan_and_check(model_scan());
        end_test("first_match");
    endtask

    task automatic test_random_tables();
        logic [15:0] v;
        for (int round = 0; round < 3; round++) begin
            for (int j = 0; j < `NUM_SINKS; j++) rand_bits(6, sink_tab[j]);
            for (int i = 0; i < `NUM_NEIGHBORS; i++) begin
                rand_bits(6, nbr_tab[i]);
                rand_bits(2, clu_tab[i]);
            end
            load_tables();
            rand_bits(2, v);
            set_cluster(v);
            scan_and_check(model_scan());
        end
        end_test("random_tables");
    endtask

    initial begin
        rst_n           = 1'b0;
        req             = 1'b0;
        cmd             = '0;
        my_cl           = '0;
        lfsr_state      = LFSR_SEED;
        checks          = 0;
        errors          = 0;
        tests_run       = 0;
        tests_bad       = 0;
        errors_at_start = 0;
        hung            = 1'b0;
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;

        test_reset_state();
        test_cmd_responses();
        test_single_match();
        test_own_cluster();
        test_first_match();
        test_random_tables();

        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* common/node_cfg.svh */
`ifndef NODE_CFG_SVH
`define NODE_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// node memory geometry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NODE_MEM_DEPTH  1024        // bytes.
`define NODE_WORD_WIDTH 16          // little-endian, two bytes.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table layout, byte addresses.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SINK_BASE       16'h0008    // known sink ids.
`define NEIGHBOR_BASE   16'h0048    // neighbor ids.
`define CLUSTER_BASE    16'h00C8    // cluster id of each neighbor.

// table lengths in words.
`define NUM_SINKS       16
`define NUM_NEIGHBORS   64

`endif

/* common/sink_pkg.sv */
`default_nettype none

`include "node_cfg.svh"

package sink_pkg;

    // host command opcodes.
    typedef enum logic [1:0] {
        OP_WRITE  = 2'd0,
        OP_CONFIG = 2'd1,
        OP_START  = 2'd2,
        OP_RESULT = 2'd3
    } host_op_e;

    // payload seen by a memory write.
    typedef struct packed {
        logic [15:0]                 addr;  // byte address, must be even.
        logic [`NODE_WORD_WIDTH-1:0] data;
    } write_view_t;

    // payload seen by a config command.
    typedef struct packed {
        logic [`NODE_WORD_WIDTH-1:0] my_cluster;
        logic [15:0]                 pad;
    } config_view_t;

    // one payload word, two decodings.
    typedef union packed {
        write_view_t  wr;
        config_view_t cfg;
    } host_payload_u;

    typedef struct packed {
        host_op_e      op;
        host_payload_u payload;
    } host_cmd_t;

    // result word as returned by OP_RESULT.
    typedef struct packed {
        logic       found;
        logic [4:0] pad;
        logic [5:0] neighbor_idx;
        logic [3:0] sink_idx;
    } scan_result_t;

    typedef struct packed {
        logic                        ok;
        logic [`NODE_WORD_WIDTH-1:0] data;
    } host_rsp_t;

    typedef struct packed {
        logic                        en;
        logic [15:0]                 addr;
        logic [`NODE_WORD_WIDTH-1:0] data;
    } mem_wr_t;

endpackage

`default_nettype wire

/* hw/host_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "node_cfg.svh"

module host_port (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire                          req,
    input  wire  sink_pkg::host_cmd_t    cmd,
    output logic                         ack,
    output sink_pkg::host_rsp_t          rsp,
    output sink_pkg::mem_wr_t            mem_wr,
    output logic                         start,
    output logic [`NODE_WORD_WIDTH-1:0]  my_cluster,
    input  wire                          done,
    input  wire  sink_pkg::scan_result_t result
);

    sink_pkg::scan_result_t result_q;   // last finished scan.
    logic                   new_req;
    logic                   addr_ok;

    assign new_req = req && !ack;       // phase one and not yet answered.

    // even and inside the array so both bytes land in range.
    assign addr_ok = !cmd.payload.wr.addr[0] &&
                     (cmd.payload.wr.addr < `NODE_MEM_DEPTH);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory write on the same edge that raises ack.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        mem_wr.en   = new_req && (cmd.op == sink_pkg::OP_WRITE) && addr_ok;
        mem_wr.addr = cmd.payload.wr.addr;
        mem_wr.data = cmd.payload.wr.data;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command decode and four-phase sequencing.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ack        <= 1'b0;
            rsp        <= '0;
            start      <= 1'b0;
            my_cluster <= '0;
            result_q   <= '0;
        end else begin
            // scan end even if the host let go of req.
            if (start && done) begin
                start    <= 1'b0;
                result_q <= result;
            end

            if (ack) begin
                if (!req) begin
                    ack <= 1'b0;                // phase four.
                end
            end else if (req) begin
                case (cmd.op)
                    sink_pkg::OP_WRITE: begin
                        ack      <= 1'b1;
                        rsp.ok   <= addr_ok;    // bad address is refused.
                        rsp.data <= '0;
                    end
                    sink_pkg::OP_CONFIG: begin
                        my_cluster <= cmd.payload.cfg.my_cluster;
                        ack        <= 1'b1;
                        rsp.ok     <= 1'b1;
                        rsp.data   <= '0;
                    end
                    sink_pkg::OP_START: begin
                        if (!start) begin
                            start <= 1'b1;      // a level held until done.
                        end else if (done) begin
                            ack      <= 1'b1;
                            rsp.ok   <= 1'b1;
                            rsp.data <= '0;
                        end
                    end
                    sink_pkg::OP_RESULT: begin
                        ack      <= 1'b1;
                        rsp.ok   <= 1'b1;
                        rsp.data <= result_q;
                    end
                    default: begin
                        ack      <= 1'b1;
                        rsp.ok   <= 1'b0;
                        rsp.data <= '0;
                    end
                endcase
            end
        end
    end

    // the host keeps req up until it sees ack.
    a_ack_after_req: assert property (
        @(posedge clock) disable iff (!rst_n)
        $rose(ack) |-> req
    );

endmodule

`default_nettype wire

/* hw/node_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "node_cfg.svh"

module node_mem (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire  sink_pkg::mem_wr_t      wr,
    input  wire  [15:0]                  rd_addr,
    output logic [`NODE_WORD_WIDTH-1:0]  rd_data
);

    localparam int ADDR_BITS = $clog2(`NODE_MEM_DEPTH);

    logic [7:0]           mem [`NODE_MEM_DEPTH];
    logic [ADDR_BITS-2:0] wr_word;  // word index of the write.
    logic [ADDR_BITS-2:0] rd_word;

    assign wr_word = wr.addr[ADDR_BITS-1:1];
    assign rd_word = rd_addr[ADDR_BITS-1:1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port, two bytes per word.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (wr.en) begin
            mem[{wr_word, 1'b0}] <= wr.data[7:0];                   // low byte.
            mem[{wr_word, 1'b1}] <= wr.data[`NODE_WORD_WIDTH-1:8];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registered read port.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else begin
            // a read of a word written on the same edge returns the old value.
            rd_data <= {mem[{rd_word, 1'b1}], mem[{rd_word, 1'b0}]};
        end
    end

    // the host port filters bad addresses before they reach the array.
    a_wr_addr_ok: assert property (
        @(posedge clock) disable iff (!rst_n)
        wr.en |-> (!wr.addr[0] && (wr.addr < `NODE_MEM_DEPTH))
    );

endmodule

`default_nettype wire

/* hw/sink_finder_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "node_cfg.svh"

module sink_finder_top (
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire                       req,
    input  wire  sink_pkg::host_cmd_t cmd,
    output logic                      ack,
    output sink_pkg::host_rsp_t       rsp
);

    sink_pkg::mem_wr_t           mem_wr;
    logic                        start;
    logic [`NODE_WORD_WIDTH-1:0] my_cluster;
    logic [15:0]                 rd_addr;
    logic [`NODE_WORD_WIDTH-1:0] rd_data;     // one cycle after rd_addr.
    logic                        done;
    sink_pkg::scan_result_t      result;

    host_port i_host_port (
        .clock      (clock),
        .rst_n      (rst_n),
        .req        (req),
        .cmd        (cmd),
        .ack        (ack),
        .rsp        (rsp),
        .mem_wr     (mem_wr),
        .start      (start),
        .my_cluster (my_cluster),
        .done       (done),
        .result     (result)
    );

    node_mem i_node_mem (
        .clock   (clock),
        .rst_n   (rst_n),
        .wr      (mem_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    sink_scan i_sink_scan (
        .clock      (clock),
        .rst_n      (rst_n),
        .start      (start),
        .my_cluster (my_cluster),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .done       (done),
        .result     (result)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the sink finder testbench with Verilator.
# Exits non-zero if the build fails, the run fails, or the pass message is missing.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sink_finder \
    -Mdir obj_dir \
    -f verilog.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/Vtb_sink_finder > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$SIM_LOG"; then
    exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1

/* sink_scan/sink_scan.sv */
`timescale 1ns/1ps
`default_nettype none

`include "node_cfg.svh"

module sink_scan (
    input  wire                          clock,
    input  wire                          rst_n,
    input  wire                          start,
    input  wire  [`NODE_WORD_WIDTH-1:0]  my_cluster,
    output logic [15:0]                  rd_addr,
    input  wire  [`NODE_WORD_WIDTH-1:0]  rd_data,
    output logic                         done,
    output sink_pkg::scan_result_t       result
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_NBR,     // neighbor id address out.
        S_CLU,     // cluster address out, neighbor id back.
        S_CHK,     // cluster back, first sink address out.
        S_CMP,     // one sink back and compared per cycle.
        S_DONE
    } scan_state_e;

    scan_state_e                 state;
    logic [5:0]                  nbr_idx;
    logic [3:0]                  sink_idx;
    logic [`NODE_WORD_WIDTH-1:0] nbr_id;    // id of the neighbor under test.
    sink_pkg::scan_result_t      result_q;

    logic own_cluster;
    logic hit;
    logic last_nbr;
    logic last_sink;
    logic next_nbr;
    logic busy;
    logic in_tables;

    function automatic logic [15:0] word_addr(input logic [15:0] base,
                                              input logic [6:0]  idx);
        return base + {8'd0, idx, 1'b0};
    endfunction

    assign own_cluster = (state == S_CHK) && (rd_data == my_cluster);
    assign hit         = (state == S_CMP) && (rd_data == nbr_id);
    assign last_nbr    = (nbr_idx == 6'(`NUM_NEIGHBORS - 1));
    assign last_sink   = (sink_idx == 4'(`NUM_SINKS - 1));

    // neighbor is finished without a match.
    assign next_nbr = own_cluster || ((state == S_CMP) && !hit && last_sink);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read address per state.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (state)
            S_NBR:   rd_addr = word_addr(`NEIGHBOR_BASE, {1'b0, nbr_idx});
            S_CLU:   rd_addr = word_addr(`CLUSTER_BASE, {1'b0, nbr_idx});
            S_CHK:   rd_addr = word_addr(`SINK_BASE, {3'd0, sink_idx});
            // one sink ahead, wraps to sink 0 on the last one.
            S_CMP:   rd_addr = word_addr(`SINK_BASE, {3'd0, sink_idx + 4'd1});
            default: rd_addr = `NEIGHBOR_BASE;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // walker FSM.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            nbr_idx  <= '0;
            sink_idx <= '0;
            result_q <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        nbr_idx  <= '0;
                        sink_idx <= '0;
                        state    <= S_NBR;
                    end
                end
                S_NBR: state <= S_CLU;
                S_CLU: state <= S_CHK;
                S_CHK: state <= S_CMP;          // own cluster handled below.
                S_CMP: begin
                    if (hit) begin
                        result_q.found        <= 1'b1;
                        result_q.pad          <= '0;
                        result_q.neighbor_idx <= nbr_idx;
                        result_q.sink_idx     <= sink_idx;
                        state                 <= S_DONE;
                    end else begin
                        sink_idx <= sink_idx + 4'd1;
                    end
                end
                default: state <= S_IDLE;       // S_DONE lasts one cycle.
            endcase

            // move on to the next neighbor, overriding the case above.
            if (next_nbr) begin
                sink_idx <= '0;
                nbr_idx  <= nbr_idx + 6'd1;
                if (last_nbr) begin
                    result_q <= '0;             // not found, indices zero.
                    state    <= S_DONE;
                end else begin
                    state <= S_NBR;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_CLU) begin
            nbr_id <= rd_data;
        end
    end

    assign done   = (state == S_DONE);
    assign result = result_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign busy = (state != S_IDLE) && (state != S_DONE);

    assign in_tables =
        ((rd_addr >= `SINK_BASE) && (rd_addr < `SINK_BASE + 2 * `NUM_SINKS)) ||
        ((rd_addr >= `NEIGHBOR_BASE) && (rd_addr < `NEIGHBOR_BASE + 2 * `NUM_NEIGHBORS)) ||
        ((rd_addr >= `CLUSTER_BASE) && (rd_addr < `CLUSTER_BASE + 2 * `NUM_NEIGHBORS));

    a_addr_in_tables: assert property (
        @(posedge clock) disable iff (!rst_n)
        busy |-> in_tables
    );

    // start is held by the host port until it has seen done.
    a_done_needs_start: assert property (
        @(posedge clock) disable iff (!rst_n)
        done |-> start
    );

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/sink_pkg.sv
hw/node_mem.sv
sink_scan/sink_scan.sv
hw/host_port.sv
hw/sink_finder_top.sv
bench/tb_sink_finder.sv
